// File: codecPkg.sv
// --------------------------------------------------------------------------
// Codec framing constants
// Sample width and bit-slot layout of one codec frame with left before right
// --------------------------------------------------------------------------
`default_nettype none

package codecPkg;

    // ----------------------------------------------------------------------
    // Sample words
    // ----------------------------------------------------------------------

    // One audio sample, DAC and ADC alike
    parameter int SampleWidth = 16;

    // ----------------------------------------------------------------------
    // Frame layout
    // ----------------------------------------------------------------------

    // Data slots per frame
    // Slots 0..15 carry left and slots 16..31 carry right
    // Each word goes MSB first
    parameter int FrameSlots = 2 * SampleWidth;

    // Width of the slot index seen by the data blocks
    // Index value FrameSlots marks the idle tail of the frame
    parameter int SlotIndexWidth = $clog2(FrameSlots) + 1;

endpackage : codecPkg

`default_nettype wire

// File: mixPkg.sv
// --------------------------------------------------------------------------
// Mixer definitions
// Mix mode encoding and the per-cycle weights of the pulse sources
// --------------------------------------------------------------------------
`default_nettype none

package mixPkg;

    // ----------------------------------------------------------------------
    // Mix modes
    // ----------------------------------------------------------------------

    // Mono sums all sources into both channels
    // Stereo splits the timer channels between left and right
    // Pcm bypasses the integrator with direct sample words
    typedef enum logic [1:0] {
        MixMono   = 2'd0,
        MixStereo = 2'd1,
        MixPcm    = 2'd2
    } MixMode;

    // ----------------------------------------------------------------------
    // Source weights added once per bit clock while a source is high
    // ----------------------------------------------------------------------

    parameter int TimerWeight  = 16;
    parameter int BeeperWeight = 32;
    parameter int TapeWeight   = 8;

    // Ceiling of a mixed sample is the largest positive 16-bit word
    parameter int SampleMax = 32767;

endpackage : mixPkg

`default_nettype wire

// File: frameTimer.sv
// --------------------------------------------------------------------------
// Codec frame timer
// Counts bit clocks per frame, makes the frame strobe and the slot index
// --------------------------------------------------------------------------
`default_nettype none

module frameTimer
    import codecPkg::*;
#(
    parameter int BitsPerFrame = 250
) (
    input  wire                      LRCK_1X,
    input  wire                      iRST_N,
    output logic                     frameStrobe,
    output logic [SlotIndexWidth-1:0] bitIndex
);

    // Counter wide enough for BitsPerFrame-1
    localparam int CountWidth = $clog2(BitsPerFrame);

    localparam logic [CountWidth-1:0] LastSlot = CountWidth'(BitsPerFrame - 1);
    localparam logic [CountWidth-1:0] PreLast  = CountWidth'(BitsPerFrame - 2);

    logic [CountWidth-1:0] slotCount;

    // ----------------------------------------------------------------------
    // Slot counter and strobe
    // ----------------------------------------------------------------------

    always_ff @(posedge LRCK_1X) begin
        if (!iRST_N) begin
            slotCount   <= '0;
            frameStrobe <= 1'b0;
        end else begin
            // Wrap at the end of the frame
            if (slotCount == LastSlot) begin
                slotCount <= '0;
            end else begin
                slotCount <= slotCount + 1'b1;
            end
            // Strobe lines up with the last slot of the frame
            frameStrobe <= (slotCount == PreLast);
        end
    end

    // ----------------------------------------------------------------------
    // Slot index
    // ----------------------------------------------------------------------

    // Follows the counter over the data slots, then parks at FrameSlots
    always_comb begin
        if (slotCount < CountWidth'(FrameSlots)) begin
            bitIndex = slotCount[SlotIndexWidth-1:0];
        end else begin
            bitIndex = SlotIndexWidth'(FrameSlots);
        end
    end

endmodule : frameTimer

`default_nettype wire

// File: pulseMixer.sv
// --------------------------------------------------------------------------
// Pulse mixer
// Integrates timer, beeper and tape pulses over a frame into two samples,
// or passes PCM words straight through
// --------------------------------------------------------------------------
`default_nettype none

module pulseMixer
    import codecPkg::*;
    import mixPkg::*;
#(
    parameter int BitsPerFrame = 250
) (
    input  wire                    LRCK_1X,
    input  wire                    iRST_N,
    input  wire                    frameStrobe,
    input  wire MixMode            mixMode,
    input  wire  [2:0]             timerOut,
    input  wire                    beeper,
    input  wire                    tapeOut,
    input  wire  [SampleWidth-1:0] pcmL,
    input  wire  [SampleWidth-1:0] pcmR,
    output logic [SampleWidth-1:0] sampleL,
    output logic [SampleWidth-1:0] sampleR
);

    // Largest per-cycle level with all five sources high
    localparam int LevelMax   = 3 * TimerWeight + BeeperWeight + TapeWeight;
    localparam int LevelWidth = $clog2(LevelMax + 1);
    // Accumulator holds a full frame of the largest level
    localparam int AccWidth   = $clog2(LevelMax * BitsPerFrame + 1);

    localparam logic [LevelWidth-1:0] TimerLevel  = LevelWidth'(TimerWeight);
    localparam logic [LevelWidth-1:0] BeeperLevel = LevelWidth'(BeeperWeight);
    localparam logic [LevelWidth-1:0] TapeLevel   = LevelWidth'(TapeWeight);

    logic [LevelWidth-1:0] levelL;
    logic [LevelWidth-1:0] levelR;
    logic [AccWidth-1:0]   accL;
    logic [AccWidth-1:0]   accR;
    logic [AccWidth-1:0]   sumL;
    logic [AccWidth-1:0]   sumR;

    // Clamp a frame sum to the sample ceiling
    function automatic logic [SampleWidth-1:0] saturate(input logic [AccWidth-1:0] sum);
        if (32'(sum) > 32'(SampleMax)) begin
            return SampleWidth'(SampleMax);
        end
        return SampleWidth'(sum);
    endfunction

    // ----------------------------------------------------------------------
    // Per-cycle channel levels
    // ----------------------------------------------------------------------

    always_comb begin
        if (mixMode == MixStereo) begin
            // Left gets timers 0 and 1 plus beeper
            levelL = (timerOut[0] ? TimerLevel : '0)
                   + (timerOut[1] ? TimerLevel : '0)
                   + (beeper ? BeeperLevel : '0);
            // Right gets timers 1 and 2 plus tape
            levelR = (timerOut[1] ? TimerLevel : '0)
                   + (timerOut[2] ? TimerLevel : '0)
                   + (tapeOut ? TapeLevel : '0);
        end else begin
            // Mono puts all sources into both channels
            levelL = (timerOut[0] ? TimerLevel : '0)
                   + (timerOut[1] ? TimerLevel : '0)
                   + (timerOut[2] ? TimerLevel : '0)
                   + (beeper ? BeeperLevel : '0)
                   + (tapeOut ? TapeLevel : '0);
            levelR = levelL;
        end
    end

    // Running sum including this cycle
    assign sumL = accL + AccWidth'(levelL);
    assign sumR = accR + AccWidth'(levelR);

    // ----------------------------------------------------------------------
    // Frame integrator and sample registers
    // ----------------------------------------------------------------------

    always_ff @(posedge LRCK_1X) begin
        if (!iRST_N) begin
            accL    <= '0;
            accR    <= '0;
            sampleL <= '0;
            sampleR <= '0;
        end else if (frameStrobe) begin
            // Close the frame and start a fresh sum
            accL <= '0;
            accR <= '0;
            if (mixMode == MixPcm) begin
                sampleL <= pcmL;
                sampleR <= pcmR;
            end else begin
                sampleL <= saturate(sumL);
                sampleR <= saturate(sumR);
            end
        end else begin
            accL <= sumL;
            accR <= sumR;
        end
    end

endmodule : pulseMixer

`default_nettype wire

// File: sampleSerializer.sv
// --------------------------------------------------------------------------
// Sample serializer
// Latches a left/right pair each frame and shifts it to the DAC MSB first
// --------------------------------------------------------------------------
`default_nettype none

module sampleSerializer
    import codecPkg::*;
(
    input  wire                      LRCK_1X,
    input  wire                      iRST_N,
    input  wire                      frameStrobe,
    input  wire  [SlotIndexWidth-1:0] bitIndex,
    input  wire  [SampleWidth-1:0]    sampleL,
    input  wire  [SampleWidth-1:0]    sampleR,
    output logic                     audData
);

    // Bit position inside the frame register
    localparam int PosWidth = $clog2(FrameSlots);

    logic [FrameSlots-1:0] frameReg;
    logic [PosWidth-1:0]   bitPos;

    // ----------------------------------------------------------------------
    // Frame register
    // ----------------------------------------------------------------------

    // Left in the upper half so it leaves first
    always_ff @(posedge LRCK_1X) begin
        if (!iRST_N) begin
            frameReg <= '0;
        end else if (frameStrobe) begin
            frameReg <= {sampleL, sampleR};
        end
    end

    // ----------------------------------------------------------------------
    // Bit select
    // ----------------------------------------------------------------------

    // Slot i carries frame bit 31-i
    assign bitPos = PosWidth'(FrameSlots - 1) - bitIndex[PosWidth-1:0];

    // Line idles low past the data slots
    always_comb begin
        if (bitIndex < SlotIndexWidth'(FrameSlots)) begin
            audData = frameReg[bitPos];
        end else begin
            audData = 1'b0;
        end
    end

endmodule : sampleSerializer

`default_nettype wire

// File: sampleDeserializer.sv
// --------------------------------------------------------------------------
// Sample deserializer
// Captures the codec ADC stream into left and right line-in words
// --------------------------------------------------------------------------
`default_nettype none

module sampleDeserializer
    import codecPkg::*;
(
    input  wire                      LRCK_1X,
    input  wire                      iRST_N,
    input  wire                      frameStrobe,
    input  wire  [SlotIndexWidth-1:0] bitIndex,
    input  wire                      audAdcData,
    output logic [SampleWidth-1:0]    lineInL,
    output logic [SampleWidth-1:0]    lineInR,
    output logic                     lineValid
);

    localparam int PosWidth = $clog2(FrameSlots);

    logic [FrameSlots-1:0] captureReg;
    logic [PosWidth-1:0]   bitPos;
    logic                  inSlot;

    // Same slot-to-bit mapping as the DAC side
    assign bitPos = PosWidth'(FrameSlots - 1) - bitIndex[PosWidth-1:0];
    assign inSlot = (bitIndex < SlotIndexWidth'(FrameSlots));

    // ----------------------------------------------------------------------
    // Capture
    // ----------------------------------------------------------------------

    // Each slot writes its own bit
    // A lost slot leaves only that bit stale
    always_ff @(posedge LRCK_1X) begin
        if (inSlot) begin
            captureReg[bitPos] <= audAdcData;
        end
    end

    // ----------------------------------------------------------------------
    // Publish
    // ----------------------------------------------------------------------

    // Both channels move out together at the frame strobe
    always_ff @(posedge LRCK_1X) begin
        if (!iRST_N) begin
            lineInL   <= '0;
            lineInR   <= '0;
            lineValid <= 1'b0;
        end else begin
            lineValid <= frameStrobe;
            if (frameStrobe) begin
                // Upper half is left
                lineInL <= captureReg[FrameSlots-1 -: SampleWidth];
                lineInR <= captureReg[SampleWidth-1:0];
            end
        end
    end

endmodule : sampleDeserializer

`default_nettype wire

// File: vectorAudio.sv
// --------------------------------------------------------------------------
// Audio path top level
// Frame timer, pulse mixer and the codec serial links on one bit clock
// --------------------------------------------------------------------------
`default_nettype none

module vectorAudio
    import codecPkg::*;
    import mixPkg::*;
#(
    parameter int BitsPerFrame = 250
) (
    // Codec bit clock and reset
    input  wire                    LRCK_1X,
    input  wire                    iRST_N,
    // Sound sources
    input  wire MixMode            mixMode,
    input  wire  [2:0]             timerOut,
    input  wire                    beeper,
    input  wire                    tapeOut,
    input  wire  [SampleWidth-1:0] pcmL,
    input  wire  [SampleWidth-1:0] pcmR,
    // Codec serial side
    input  wire                    audAdcData,
    output logic                   audLrck,
    output logic                   audData,
    // Line-in samples
    output logic [SampleWidth-1:0] lineInL,
    output logic [SampleWidth-1:0] lineInR,
    output logic                   lineValid
);

    logic                      frameStrobe;
    logic [SlotIndexWidth-1:0] bitIndex;
    logic [SampleWidth-1:0]    sampleL;
    logic [SampleWidth-1:0]    sampleR;

    // Frame strobe doubles as the codec word clock
    assign audLrck = frameStrobe;

    // ----------------------------------------------------------------------
    // Frame timing
    // ----------------------------------------------------------------------

    frameTimer #(
        .BitsPerFrame (BitsPerFrame)
    ) i_frameTimer (
        .LRCK_1X     (LRCK_1X),
        .iRST_N      (iRST_N),
        .frameStrobe (frameStrobe),
        .bitIndex    (bitIndex)
    );

    // ----------------------------------------------------------------------
    // DAC path
    // ----------------------------------------------------------------------

    pulseMixer #(
        .BitsPerFrame (BitsPerFrame)
    ) i_pulseMixer (
        .LRCK_1X     (LRCK_1X),
        .iRST_N      (iRST_N),
        .frameStrobe (frameStrobe),
        .mixMode     (mixMode),
        .timerOut    (timerOut),
        .beeper      (beeper),
        .tapeOut     (tapeOut),
        .pcmL        (pcmL),
        .pcmR        (pcmR),
        .sampleL     (sampleL),
        .sampleR     (sampleR)
    );

    sampleSerializer i_sampleSerializer (
        .LRCK_1X     (LRCK_1X),
        .iRST_N      (iRST_N),
        .frameStrobe (frameStrobe),
        .bitIndex    (bitIndex),
        .sampleL     (sampleL),
        .sampleR     (sampleR),
        .audData     (audData)
    );

    // ----------------------------------------------------------------------
    // ADC path
    // ----------------------------------------------------------------------

    sampleDeserializer i_sampleDeserializer (
        .LRCK_1X     (LRCK_1X),
        .iRST_N      (iRST_N),
        .frameStrobe (frameStrobe),
        .bitIndex    (bitIndex),
        .audAdcData  (audAdcData),
        .lineInL     (lineInL),
        .lineInR     (lineInR),
        .lineValid   (lineValid)
    );

endmodule : vectorAudio

`default_nettype wire

// File: clockGen.sv
// --------------------------------------------------------------------------
// Testbench clock source
// Free-running codec bit clock for the audio path testbench
// --------------------------------------------------------------------------
`default_nettype none

module clockGen #(
    parameter int Period = 100
) (
    output logic LRCK_1X
);

    // Starts low, first rising edge after half a period
    initial begin
        LRCK_1X = 1'b0;
        forever begin
            #(Period / 2) LRCK_1X = ~LRCK_1X;
        end
    end

endmodule : clockGen

`default_nettype wire

// File: audioTb.sv
// --------------------------------------------------------------------------
// Audio path testbench
// Replays the pattern steps, decodes the DAC stream, feeds the ADC stream
// and checks every result against the mixing rule
// --------------------------------------------------------------------------
`default_nettype none

module audioTb
    import codecPkg::*;
    import mixPkg::*;
();

    localparam int BitsPerFrame  = 40;
    localparam int FramesPerStep = 4;
    localparam int NumSteps      = 16;
    localparam int StepCycles    = FramesPerStep * BitsPerFrame;
    localparam int ClockPeriod   = 100;
    localparam int ResetCycles   = 5;
    localparam int PatternWidth  = 116;
    localparam int PosWidth      = $clog2(FrameSlots);
    // Whole run plus four frames of slack
    localparam int TimeoutTime   = (NumSteps * StepCycles + 4 * BitsPerFrame) * ClockPeriod;

    // DUT ports
    logic                   LRCK_1X;
    logic                   iRST_N;
    MixMode                 mixMode;
    logic [2:0]             timerOut;
    logic                   beeper;
    logic                   tapeOut;
    logic [SampleWidth-1:0] pcmL;
    logic [SampleWidth-1:0] pcmR;
    logic                   audAdcData;
    logic                   audLrck;
    logic                   audData;
    logic [SampleWidth-1:0] lineInL;
    logic [SampleWidth-1:0] lineInR;
    logic                   lineValid;

    // Pattern table and the fields of the current step
    logic [PatternWidth-1:0] patterns [0:NumSteps-1];
    MixMode                  stepMode;
    logic                    stepRandom;
    logic [2:0]              stepTimer;
    logic                    stepBeeper;
    logic                    stepTape;
    logic [SampleWidth-1:0]  stepPcmL;
    logic [SampleWidth-1:0]  stepPcmR;
    logic [SampleWidth-1:0]  stepAdcL;
    logic [SampleWidth-1:0]  stepAdcR;
    logic [SampleWidth-1:0]  stepExpL;
    logic [SampleWidth-1:0]  stepExpR;

    // Run state, receiver and ADC source
    int                      cyc;
    int                      rxSlot;
    int                      checkCount;
    integer                  seed;
    logic                    lrckSeen;
    logic [FrameSlots-1:0]   rxWord;
    logic [FrameSlots-1:0]   adcFrame;
    logic [SampleWidth-1:0]  lastAdcL;
    logic [SampleWidth-1:0]  lastAdcR;

    clockGen #(
        .Period (ClockPeriod)
    ) i_clockGen (
        .LRCK_1X (LRCK_1X)
    );

    vectorAudio #(
        .BitsPerFrame (BitsPerFrame)
    ) i_dut (
        .LRCK_1X    (LRCK_1X),
        .iRST_N     (iRST_N),
        .mixMode    (mixMode),
        .timerOut   (timerOut),
        .beeper     (beeper),
        .tapeOut    (tapeOut),
        .pcmL       (pcmL),
        .pcmR       (pcmR),
        .audAdcData (audAdcData),
        .audLrck    (audLrck),
        .audData    (audData),
        .lineInL    (lineInL),
        .lineInR    (lineInR),
        .lineValid  (lineValid)
    );

    // ----------------------------------------------------------------------
    // Reporting and compares
    // ----------------------------------------------------------------------

    task automatic failRun(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic checkSample(input string name, input logic [SampleWidth-1:0] got,
                               input logic [SampleWidth-1:0] exp);
        checkCount++;
        if (got !== exp) begin
            failRun($sformatf("MISMATCH time=%0t signal=%s got=%h expected=%h",
                              $time, name, got, exp));
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            failRun($sformatf("MISMATCH time=%0t signal=%s got=%b expected=%b",
                              $time, name, got, exp));
        end
    endtask

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------

    // Weighted sources times frame length and clipped at the ceiling
    function automatic logic [SampleWidth-1:0] expectedSample(
        input MixMode mode, input logic [2:0] timers, input logic beep,
        input logic tape, input logic [SampleWidth-1:0] pcm, input logic rightSide);
        int level;
        int total;
        if (mode == MixPcm) begin
            return pcm;
        end
        level = 0;
        // Stereo left skips timer 2 and tape, stereo right skips timer 0 and beeper
        if (timers[0] && !(mode == MixStereo && rightSide)) level += TimerWeight;
        if (timers[1]) level += TimerWeight;
        if (timers[2] && !(mode == MixStereo && !rightSide)) level += TimerWeight;
        if (beep && !(mode == MixStereo && rightSide)) level += BeeperWeight;
        if (tape && !(mode == MixStereo && !rightSide)) level += TapeWeight;
        total = level * BitsPerFrame;
        if (total > SampleMax) begin
            total = SampleMax;
        end
        return SampleWidth'(total);
    endfunction

    // Random pulse steps only check the PCM and ADC paths
    function automatic logic hasDacExpectation();
        return !stepRandom || stepMode == MixPcm;
    endfunction

    // Row columns are mode, random, timers, beeper, tape, pcmL, pcmR, adcL, adcR, expL, expR
    task automatic loadStep(input int idx);
        logic [PatternWidth-1:0] row;
        row        = patterns[idx];
        stepMode   = MixMode'(row[113:112]);
        stepRandom = row[108];
        stepTimer  = row[106:104];
        stepBeeper = row[100];
        stepTape   = row[96];
        stepPcmL   = row[95:80];
        stepPcmR   = row[79:64];
        stepAdcL   = row[63:48];
        stepAdcR   = row[47:32];
        stepExpL   = row[31:16];
        stepExpR   = row[15:0];
    endtask

    // ----------------------------------------------------------------------
    // Per-cycle drive and sample
    // ----------------------------------------------------------------------

    task automatic driveCycle();
        int slotNow;
        int stepIdx;
        int frameInStep;
        slotNow     = cyc % BitsPerFrame;
        stepIdx     = cyc / StepCycles;
        frameInStep = (cyc / BitsPerFrame) % FramesPerStep;
        iRST_N <= 1'b1;
        // Last step stays applied over the trailing cycle
        if (cyc % StepCycles == 0 && stepIdx < NumSteps) begin
            loadStep(stepIdx);
            mixMode <= stepMode;
            pcmL    <= stepPcmL;
            pcmR    <= stepPcmR;
        end
        if (stepRandom) begin
            timerOut <= 3'($random(seed));
            beeper   <= 1'($random(seed));
            tapeOut  <= 1'($random(seed));
        end else begin
            timerOut <= stepTimer;
            beeper   <= stepBeeper;
            tapeOut  <= stepTape;
        end
        // Fresh ADC words each frame with an offset so neighbouring frames differ
        if (slotNow == 0) begin
            lastAdcL = adcFrame[FrameSlots-1 -: SampleWidth];
            lastAdcR = adcFrame[SampleWidth-1:0];
            adcFrame = {stepAdcL + SampleWidth'(frameInStep),
                        stepAdcR - SampleWidth'(frameInStep)};
        end
        if (slotNow < FrameSlots) begin
            audAdcData <= adcFrame[PosWidth'(FrameSlots - 1 - slotNow)];
        end else begin
            audAdcData <= 1'b0;
        end
    endtask

    task automatic sampleCycle();
        int slotNow;
        int frameIdx;
        logic [SampleWidth-1:0] expL;
        logic [SampleWidth-1:0] expR;
        slotNow  = cyc % BitsPerFrame;
        frameIdx = cyc / BitsPerFrame;
        // Word clock in the last slot of every frame
        checkBit("audLrck", audLrck, slotNow == BitsPerFrame - 1);
        // Previous frame's ADC words show up in slot 0
        checkBit("lineValid", lineValid, slotNow == 0 && frameIdx > 0);
        if (slotNow == 0 && frameIdx > 0) begin
            checkSample("lineInL", lineInL, lastAdcL);
            checkSample("lineInR", lineInR, lastAdcR);
        end
        // Receiver restarts its slot count after each word clock
        if (lrckSeen) begin
            rxSlot = 0;
        end else if (rxSlot >= 0) begin
            rxSlot++;
        end
        lrckSeen = audLrck;
        if (rxSlot >= 0 && rxSlot < FrameSlots) begin
            rxWord[PosWidth'(FrameSlots - 1 - rxSlot)] = audData;
        end else begin
            checkBit("audData", audData, 1'b0);
        end
        // Last frame of a step carries the settled samples
        if (slotNow == BitsPerFrame - 1 && frameIdx % FramesPerStep == FramesPerStep - 1
                && hasDacExpectation()) begin
            expL = expectedSample(stepMode, stepTimer, stepBeeper, stepTape, stepPcmL, 1'b0);
            expR = expectedSample(stepMode, stepTimer, stepBeeper, stepTape, stepPcmR, 1'b1);
            checkSample("audData left", rxWord[FrameSlots-1 -: SampleWidth], expL);
            checkSample("audData right", rxWord[SampleWidth-1:0], expR);
        end
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------

    initial begin
        seed       = 60;
        checkCount = 0;
        rxSlot     = -1;
        lrckSeen   = 1'b0;
        rxWord     = '0;
        adcFrame   = '0;
        lastAdcL   = '0;
        lastAdcR   = '0;
        iRST_N     <= 1'b0;
        mixMode    <= MixMono;
        timerOut   <= '0;
        beeper     <= 1'b0;
        tapeOut    <= 1'b0;
        pcmL       <= '0;
        pcmR       <= '0;
        audAdcData <= 1'b0;
        $readmemh("vectorAudio_patterns.txt", patterns);
        if ($isunknown(patterns[NumSteps-1])) begin
            failRun("Pattern file holds fewer steps than the testbench expects");
        end
        // Expected columns must agree with the mixing rule
        for (int s = 0; s < NumSteps; s++) begin
            loadStep(s);
            if (hasDacExpectation() && (stepExpL !== expectedSample(stepMode, stepTimer,
                    stepBeeper, stepTape, stepPcmL, 1'b0) || stepExpR !== expectedSample(
                    stepMode, stepTimer, stepBeeper, stepTape, stepPcmR, 1'b1))) begin
                failRun($sformatf("Pattern step %0d lists samples that break the mixing rule", s));
            end
        end
        // Outputs stay low while reset is held
        // The first loop edge is the last reset edge
        repeat (ResetCycles - 1) begin
            @(posedge LRCK_1X);
            @(negedge LRCK_1X);
            checkBit("audLrck", audLrck, 1'b0);
            checkBit("lineValid", lineValid, 1'b0);
            checkBit("audData", audData, 1'b0);
        end
        for (cyc = 0; cyc <= NumSteps * StepCycles; cyc++) begin
            @(posedge LRCK_1X);
            driveCycle();
            @(negedge LRCK_1X);
            sampleCycle();
        end
        if (checkCount > 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("No checks were executed");
            $display("CHECKS FAILED");
            $fatal(1, "empty run");
        end
    end

    // Watchdog against a stalled run
    initial begin
        #(TimeoutTime);
        $display("Timeout: the run did not finish within %0d time units", TimeoutTime);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule : audioTb

`default_nettype wire

// File: vectorAudio_patterns.txt
// mode_random_timers_beeper_tape_pcmL_pcmR_adcL_adcR_expL_expR, all hex
// mode 0 mono, 1 stereo, 2 pcm; random 1 drives the pulse sources from $random
0_0_0_0_0_0000_0000_A5A5_5A5A_0000_0000
0_0_1_0_0_0000_0000_8000_0001_0280_0280
0_0_7_1_1_0000_0000_FFFF_0000_0DC0_0DC0
0_0_0_1_0_0000_0000_0000_FFFF_0500_0500
0_0_0_0_1_0000_0000_1234_5678_0140_0140
1_0_1_0_0_0000_0000_0001_8000_0280_0000
1_0_4_0_0_0000_0000_7FFF_FFFE_0000_0280
1_0_2_0_0_0000_0000_C3C3_3C3C_0280_0280
1_0_0_1_0_0000_0000_DEAD_BEEF_0500_0000
1_0_0_0_1_0000_0000_0F0F_F0F0_0000_0140
1_0_7_1_1_0000_0000_AAAA_5555_0A00_0640
2_1_0_0_0_8000_0001_1357_9BDF_8000_0001
2_1_0_0_0_7FFF_FFFE_2468_ACE0_7FFF_FFFE
2_1_0_0_0_0000_FFFF_FFFC_0003_0000_FFFF
0_1_0_0_0_0000_0000_6C6C_9393_0000_0000
1_1_0_0_0_0000_0000_0000_0000_0000_0000

// File: vectorAudio.f
codecPkg.sv
mixPkg.sv
frameTimer.sv
pulseMixer.sv
sampleSerializer.sv
sampleDeserializer.sv
vectorAudio.sv
clockGen.sv
audioTb.sv

// File: runSim.sh
#!/bin/sh
# Build and run the audio path testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module audioTb -f vectorAudio.f -o audioSim || exit 1
simOut=$(./obj_dir/audioSim)
echo "$simOut"
echo "$simOut" | grep -qx "ALL CHECKS PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
